/* logic/corr_pkg.sv */
package corr_pkg;

	localparam int RESOLUTION = 16; // Two bytes per count.

	typedef logic [RESOLUTION-1:0] count_t;

	localparam count_t COUNT_MAX = '1; // Saturation value.

	// Host command bytes.
	localparam logic [7:0] CMD_START = 8'h01;
	localparam logic [7:0] CMD_STOP = 8'h02;
	localparam logic [7:0] CMD_MASK = 8'h03;

	// Packet framing.
	localparam logic [7:0] PKT_HEAD = 8'hA5;
	localparam logic [7:0] PKT_FOOT = 8'h5A;

endpackage

/* logic/line_sampler.sv */
`timescale 1ns/1ns

module line_sampler #(
	parameter int NUM_INPUTS = 4,
	parameter int LAG = 4
) (
	input logic intclk,
	input logic rst_n,
	input logic [NUM_INPUTS-1:0] line_in,
	input logic [NUM_INPUTS-1:0] invert_mask,
	output logic [NUM_INPUTS-1:0] samples,
	output logic [NUM_INPUTS*LAG-1:0] history
);

	logic [NUM_INPUTS-1:0] sync_q;

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			sync_q <= '0;
			samples <= '0;
		end else begin
			sync_q <= line_in; // First stage.
			samples <= sync_q ^ invert_mask; // Polarity applied here.
		end
	end

	// Bit i*LAG+k-1 is line i delayed by k cycles.
	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			history <= '0;
		end else begin
			for (int i = 0; i < NUM_INPUTS; i++) begin
				history[i*LAG +: LAG] <= {history[i*LAG +: LAG-1], samples[i]};
			end
		end
	end

endmodule

/* logic/pulse_counter.sv */
`timescale 1ns/1ns

module pulse_counter import corr_pkg::*; #(
	parameter int NUM_INPUTS = 4
) (
	input logic intclk,
	input logic rst_n,
	input logic [NUM_INPUTS-1:0] samples,
	input logic integrating,
	input logic clear,
	output count_t [NUM_INPUTS-1:0] counts
);

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			counts <= '0;
		end else if (clear) begin
			counts <= '0; // New window.
		end else if (integrating) begin
			for (int i = 0; i < NUM_INPUTS; i++) begin
				if (samples[i] && counts[i] != COUNT_MAX) begin
					counts[i] <= counts[i] + 1'b1; // Holds at max.
				end
			end
		end
	end

endmodule

/* logic/correlator.sv */
`timescale 1ns/1ns

module correlator import corr_pkg::*; #(
	parameter int NUM_INPUTS = 4,
	parameter int LAG = 4,
	parameter bit CROSS = 1'b0,
	localparam int NUM_BASELINES = NUM_INPUTS*(NUM_INPUTS-1)/2,
	localparam int NUM_CH = CROSS ? NUM_BASELINES : NUM_INPUTS
) (
	input logic intclk,
	input logic rst_n,
	input logic [NUM_INPUTS-1:0] samples,
	input logic [NUM_INPUTS*LAG-1:0] history,
	input logic integrating,
	input logic clear,
	output count_t [NUM_CH*LAG-1:0] counts
);

	logic [NUM_CH*LAG-1:0] hit; // One coincidence per channel and lag.

	if (CROSS) begin : g_cross
		for (genvar a = 0; a < NUM_INPUTS; a++) begin : g_a
			for (genvar b = a + 1; b < NUM_INPUTS; b++) begin : g_b
				// Baselines ordered (0,1), (0,2) ... (1,2) ...
				localparam int BL = a*NUM_INPUTS - a*(a+1)/2 + b - a - 1;

				assign hit[BL*LAG] = samples[a] & samples[b]; // Zero lag.
				for (genvar k = 1; k < LAG; k++) begin : g_lag
					assign hit[BL*LAG+k] = history[a*LAG+k-1] & samples[b];
				end
			end
		end
	end else begin : g_auto
		for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_line
			for (genvar k = 0; k < LAG; k++) begin : g_lag
				assign hit[i*LAG+k] = samples[i] & history[i*LAG+k]; // Lag k+1.
			end
		end
	end

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			counts <= '0;
		end else if (clear) begin
			counts <= '0;
		end else if (integrating) begin
			for (int n = 0; n < NUM_CH*LAG; n++) begin
				if (hit[n] && counts[n] != COUNT_MAX) begin
					counts[n] <= counts[n] + 1'b1;
				end
			end
		end
	end

endmodule

/* logic/cmd_parser.sv */
`timescale 1ns/1ns

module cmd_parser import corr_pkg::*; #(
	parameter int NUM_INPUTS = 4
) (
	input logic intclk,
	input logic rst_n,
	input logic [7:0] rx_data,
	input logic rx_valid,
	input logic busy,
	output logic integrating,
	output logic clear,
	output logic stop_strobe,
	output logic [NUM_INPUTS-1:0] invert_mask
);

	typedef enum logic {
		ST_CMD,
		ST_MASK
	} state_t;

	state_t state;
	logic take;

	assign take = rx_valid & ~busy; // Drop bytes during a packet.

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_CMD;
			integrating <= 1'b0;
			clear <= 1'b0;
			stop_strobe <= 1'b0;
			invert_mask <= '0;
		end else begin
			clear <= 1'b0;
			stop_strobe <= 1'b0;
			if (take) begin
				if (state == ST_MASK) begin
					invert_mask <= rx_data[NUM_INPUTS-1:0]; // Mask operand.
					state <= ST_CMD;
				end else begin
					case (rx_data)
						CMD_START: begin
							integrating <= 1'b1;
							clear <= 1'b1; // Also restarts a running window.
						end
						CMD_STOP: begin
							if (integrating) begin
								integrating <= 1'b0;
								stop_strobe <= 1'b1;
							end
						end
						CMD_MASK: state <= ST_MASK;
						default: state <= ST_CMD;
					endcase
				end
			end
		end
	end

endmodule

/* logic/packet_tx.sv */
`timescale 1ns/1ns

module packet_tx import corr_pkg::*; #(
	parameter int NUM_INPUTS = 4,
	parameter int LAG = 4,
	localparam int NUM_BASELINES = NUM_INPUTS*(NUM_INPUTS-1)/2,
	localparam int NUM_WORDS = NUM_INPUTS + (NUM_INPUTS + NUM_BASELINES)*LAG,
	localparam int NUM_BYTES = 2*NUM_WORDS + 2,
	localparam int IDX_W = $clog2(NUM_BYTES)
) (
	input logic intclk,
	input logic rst_n,
	input logic stop_strobe,
	input count_t [NUM_INPUTS-1:0] line_counts,
	input count_t [NUM_INPUTS*LAG-1:0] auto_counts,
	input count_t [NUM_BASELINES*LAG-1:0] cross_counts,
	output logic [7:0] tx_data,
	output logic tx_valid,
	output logic busy
);

	count_t [NUM_WORDS-1:0] frame;
	logic [IDX_W-1:0] idx;
	logic [IDX_W-1:0] pos;
	logic [IDX_W-2:0] word;
	logic sending;

	// Word 0 is line 0 total, cross counts last.
	always_ff @(posedge intclk) begin
		if (stop_strobe) begin
			frame <= {cross_counts, auto_counts, line_counts};
		end
	end

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			sending <= 1'b0;
			idx <= '0;
		end else if (stop_strobe) begin
			sending <= 1'b1;
			idx <= '0;
		end else if (sending) begin
			if (idx == IDX_W'(NUM_BYTES-1)) begin
				sending <= 1'b0; // Footer was sent.
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	assign pos = idx - 1'b1; // Payload byte number.
	assign word = pos[IDX_W-1:1];

	always_comb begin
		if (idx == '0) begin
			tx_data = PKT_HEAD;
		end else if (idx == IDX_W'(NUM_BYTES-1)) begin
			tx_data = PKT_FOOT;
		end else if (!pos[0]) begin
			tx_data = frame[word][15:8]; // High byte first.
		end else begin
			tx_data = frame[word][7:0];
		end
	end

	assign tx_valid = sending;
	assign busy = stop_strobe | sending;

endmodule

/* logic/corr_top.sv */
`timescale 1ns/1ns

module corr_top import corr_pkg::*; #(
	parameter int NUM_INPUTS = 4,
	parameter int LAG = 4
) (
	input logic intclk,
	input logic rst_n,
	input logic [NUM_INPUTS-1:0] line_in,
	input logic [7:0] rx_data,
	input logic rx_valid,
	output logic [7:0] tx_data,
	output logic tx_valid,
	output logic busy
);

	localparam int NUM_BASELINES = NUM_INPUTS*(NUM_INPUTS-1)/2;

	logic integrating;
	logic clear;
	logic stop_strobe;
	logic [NUM_INPUTS-1:0] invert_mask;
	logic [NUM_INPUTS-1:0] samples;
	logic [NUM_INPUTS*LAG-1:0] history;
	count_t [NUM_INPUTS-1:0] line_counts;
	count_t [NUM_INPUTS*LAG-1:0] auto_counts;
	count_t [NUM_BASELINES*LAG-1:0] cross_counts;

	line_sampler #(.NUM_INPUTS(NUM_INPUTS), .LAG(LAG)) i_sampler (
		.intclk(intclk),
		.rst_n(rst_n),
		.line_in(line_in),
		.invert_mask(invert_mask),
		.samples(samples),
		.history(history)
	);

	pulse_counter #(.NUM_INPUTS(NUM_INPUTS)) i_counter (
		.intclk(intclk),
		.rst_n(rst_n),
		.samples(samples),
		.integrating(integrating),
		.clear(clear),
		.counts(line_counts)
	);

	correlator #(.NUM_INPUTS(NUM_INPUTS), .LAG(LAG), .CROSS(1'b0)) auto_corr (
		.intclk(intclk),
		.rst_n(rst_n),
		.samples(samples),
		.history(history),
		.integrating(integrating),
		.clear(clear),
		.counts(auto_counts)
	);

	correlator #(.NUM_INPUTS(NUM_INPUTS), .LAG(LAG), .CROSS(1'b1)) cross_corr (
		.intclk(intclk),
		.rst_n(rst_n),
		.samples(samples),
		.history(history),
		.integrating(integrating),
		.clear(clear),
		.counts(cross_counts)
	);

	cmd_parser #(.NUM_INPUTS(NUM_INPUTS)) i_parser (
		.intclk(intclk),
		.rst_n(rst_n),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.busy(busy),
		.integrating(integrating),
		.clear(clear),
		.stop_strobe(stop_strobe),
		.invert_mask(invert_mask)
	);

	packet_tx #(.NUM_INPUTS(NUM_INPUTS), .LAG(LAG)) i_tx (
		.intclk(intclk),
		.rst_n(rst_n),
		.stop_strobe(stop_strobe),
		.line_counts(line_counts),
		.auto_counts(auto_counts),
		.cross_counts(cross_counts),
		.tx_data(tx_data),
		.tx_valid(tx_valid),
		.busy(busy)
	);

endmodule

/* include/corr_model.svh */
`ifndef CORR_MODEL_SVH
`define CORR_MODEL_SVH

typedef logic [7:0] corr_byte_q_t[$];

// Cycles where line a, k samples earlier, and line b now are both high.
function automatic corr_pkg::count_t corr_term(input logic [7:0] hist[$],
		input logic [7:0] mask, input int a, input int b, input int k);
	int unsigned n;
	logic [7:0] early;
	logic [7:0] late;
	n = 0;
	for (int t = k; t < hist.size(); t++) begin
		early = hist[t-k] ^ mask;
		late = hist[t] ^ mask;
		if (early[a] && late[b])
			n++;
	end
	return (n > corr_pkg::COUNT_MAX) ? corr_pkg::COUNT_MAX : corr_pkg::count_t'(n);
endfunction

// Expected packet for one window of driven line vectors.
function automatic corr_byte_q_t corr_model(input logic [7:0] hist[$],
		input logic [7:0] mask, input int num_inputs, input int lag);
	corr_byte_q_t pkt;
	corr_pkg::count_t c[$];
	for (int i = 0; i < num_inputs; i++)
		c.push_back(corr_term(hist, mask, i, i, 0)); // Totals.
	for (int i = 0; i < num_inputs; i++)
		for (int k = 1; k <= lag; k++)
			c.push_back(corr_term(hist, mask, i, i, k));
	for (int a = 0; a < num_inputs; a++)
		for (int b = a + 1; b < num_inputs; b++)
			for (int k = 0; k < lag; k++)
				c.push_back(corr_term(hist, mask, a, b, k));
	pkt.push_back(corr_pkg::PKT_HEAD);
	foreach (c[n]) begin
		pkt.push_back(c[n][15:8]);
		pkt.push_back(c[n][7:0]);
	end
	pkt.push_back(corr_pkg::PKT_FOOT);
	return pkt;
endfunction

`endif

/* test/tb_corr_top.sv */
`timescale 1ns/1ns

module tb_corr_top import corr_pkg::*; ();

	localparam int NUM_INPUTS = 4;
	localparam int LAG = 4;
	localparam int NUM_BASELINES = NUM_INPUTS*(NUM_INPUTS-1)/2;
	localparam int PKT_BYTES = 2*(NUM_INPUTS + (NUM_INPUTS + NUM_BASELINES)*LAG) + 2;
	localparam int WINDOW = 200;
	localparam int SAT_WINDOW = 70000; // Past the count_t maximum.
	localparam int TIMEOUT_CYCLES = 4000;

	`include "corr_model.svh"

	logic intclk;
	logic rst_n;
	logic [NUM_INPUTS-1:0] line_in;
	logic [7:0] rx_data;
	logic rx_valid;
	logic [7:0] tx_data;
	logic tx_valid;
	logic busy;

	int seed;
	int cycles = 0;
	int cycle_limit = TIMEOUT_CYCLES;
	int pkts_done = 0;
	string test_name;
	logic [NUM_INPUTS-1:0] mask_now; // Idle line level as well.
	logic [7:0] drive_log[$];
	corr_byte_q_t exp_pkt;
	corr_byte_q_t got_pkt;
	corr_byte_q_t last_pkt;

	corr_top #(.NUM_INPUTS(NUM_INPUTS), .LAG(LAG)) i_dut (.*);

	initial begin
		intclk = 1'b0;
		forever #4 intclk = ~intclk;
	end

	task automatic report_failure();
		$display("Test failures found");
		$fatal(1, "Stopped at the first failing check.");
	endtask

	task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act) begin
			$display("ERR %s, %s: expected %02h, actual %02h", test_name, what, exp, act);
			report_failure();
		end
	endtask

	task automatic check_count(input string what, input count_t exp, input count_t act);
		if (exp !== act) begin
			$display("ERR %s, %s: expected %04h, actual %04h", test_name, what, exp, act);
			report_failure();
		end
	endtask

	task automatic check_len(input string what, input int exp, input int act);
		if (exp != act) begin
			$display("ERR %s, %s: expected %0d, actual %0d", test_name, what, exp, act);
			report_failure();
		end
	endtask

	task automatic compare_packet();
		int words;
		check_len("packet length", PKT_BYTES, got_pkt.size());
		check_byte("header", exp_pkt[0], got_pkt[0]);
		words = (PKT_BYTES - 2) / 2;
		for (int n = 0; n < words; n++) begin
			check_count($sformatf("word %0d", n), count_t'({exp_pkt[2*n+1], exp_pkt[2*n+2]}),
				count_t'({got_pkt[2*n+1], got_pkt[2*n+2]}));
		end
		check_byte("footer", exp_pkt[PKT_BYTES-1], got_pkt[PKT_BYTES-1]);
	endtask

	task automatic idle_lines(input int n);
		repeat (n) begin
			@(negedge intclk);
			line_in = mask_now; // Conditions to all zero.
			rx_valid = 1'b0;
		end
	endtask

	task automatic strobe(input logic [7:0] b);
		@(negedge intclk);
		rx_data = b;
		rx_valid = 1'b1;
		@(negedge intclk);
		rx_valid = 1'b0;
	endtask

	task automatic command(input logic [7:0] b);
		idle_lines(4);
		strobe(b);
		idle_lines(3);
	endtask

	// Negative held draws random lines, otherwise that line alone is high.
	task automatic run_window(input string name, input int n, input int held, input bit poke);
		logic [NUM_INPUTS-1:0] v;
		int target;
		test_name = name;
		drive_log.delete();
		command(CMD_START);
		for (int i = 0; i < n; i++) begin
			@(negedge intclk);
			if (held < 0)
				v = NUM_INPUTS'($random(seed));
			else
				v = mask_now ^ NUM_INPUTS'(1 << held);
			line_in = v;
			drive_log.push_back(8'(v));
		end
		exp_pkt = corr_model(drive_log, 8'(mask_now), NUM_INPUTS, LAG);
		target = pkts_done + 1;
		command(CMD_STOP);
		if (poke) begin
			if (!busy) begin
				$display("busy was low while the packet was being sent.");
				report_failure();
			end
			strobe(CMD_START); // All dropped while busy.
			strobe(CMD_MASK);
			strobe(8'h0F);
		end
		wait (pkts_done == target);
	endtask

	// Bytes taken mid-cycle, packet checked when tx_valid drops.
	always @(negedge intclk) begin
		if (tx_valid) begin
			got_pkt.push_back(tx_data);
		end else if (got_pkt.size() != 0) begin
			compare_packet();
			last_pkt = got_pkt;
			got_pkt.delete();
			pkts_done++;
		end
	end

	always @(posedge intclk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout after %0d clock cycles, the packet never finished.", cycles);
			report_failure();
		end
	end

	initial begin
		int n;
		seed = 32'h99ac_d8d8;
		rst_n = 1'b0;
		line_in = '0;
		rx_data = '0;
		rx_valid = 1'b0;
		mask_now = '0;
		repeat (10) @(posedge intclk);
		@(negedge intclk);
		rst_n = 1'b1;

		test_name = "idle_after_reset";
		repeat (20) begin
			@(negedge intclk);
			if (tx_valid || busy) begin
				$display("tx_valid or busy went high with no command sent.");
				report_failure();
			end
		end
		run_window("empty_window", 0, -1, 1'b0);
		run_window("random_lines", WINDOW, -1, 1'b0);

		command(CMD_MASK);
		command(8'h0A);
		mask_now = 4'b1010;
		idle_lines(8); // Flush the history with the new level.
		run_window("inverted_lines", WINDOW, -1, 1'b0);

		run_window("busy_ignore", WINDOW, -1, 1'b1);
		command(CMD_STOP); // Window must still be closed.
		idle_lines(20);
		check_len("stray packet bytes", 0, got_pkt.size());
		run_window("fresh_window", WINDOW, -1, 1'b0);

		cycle_limit = cycles + SAT_WINDOW + TIMEOUT_CYCLES;
		run_window("saturation", SAT_WINDOW, 2, 1'b0);
		for (int k = 0; k <= LAG; k++) begin
			n = (k == 0) ? 2 : NUM_INPUTS + 2*LAG + k - 1;
			check_count($sformatf("line 2 lag %0d saturated", k), COUNT_MAX,
				count_t'({last_pkt[2*n+1], last_pkt[2*n+2]}));
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

/* files.f */
+incdir+include
logic/corr_pkg.sv
logic/line_sampler.sv
logic/pulse_counter.sv
logic/correlator.sv
logic/cmd_parser.sv
logic/packet_tx.sv
logic/corr_top.sv
test/tb_corr_top.sv

/* run.sh */
#!/bin/sh
# Builds the correlator testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_corr_top -f files.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed."
	exit 1
fi

output=$(./obj_dir/Vtb_corr_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status."
	exit 1
fi

if echo "$output" | grep -qF "All tests passed!"; then
	exit 0
fi
exit 1
